// File: ramtest_pkg.sv
// Shared widths, register map and transfer states for the loopback engine
package ramtest_pkg;

  // --------------------------------------------------
  // Data widths
  // --------------------------------------------------
  localparam int PIPE_W = 16;
  localparam int MEM_W  = 32;

  typedef logic [PIPE_W-1:0] pipe_word_t;
  typedef logic [MEM_W-1:0]  mem_word_t;

  // --------------------------------------------------
  // Wishbone register map
  // --------------------------------------------------
  typedef logic [1:0]  wb_addr_t;
  typedef logic [15:0] wb_data_t;

  localparam wb_addr_t CTRL_ADDR = 2'd0;
  localparam wb_addr_t STAT_ADDR = 2'd1;

  // Control register bits
  localparam int CTRL_RD_BIT  = 0;
  localparam int CTRL_WR_BIT  = 1;
  localparam int CTRL_RST_BIT = 2;

  typedef enum logic [1:0] {
    XFER_IDLE      = 2'd0,
    XFER_WRITE     = 2'd1,
    XFER_READ_ADDR = 2'd2,
    XFER_READ      = 2'd3
  } xfer_state_t;

endpackage

// File: word_ram.sv
// Single-port word memory standing in for the external DRAM
module word_ram import ramtest_pkg::*; #(
  parameter int MEM_ADDR_W = 8
) (
  input  logic                  ti_clk,
  input  logic                  mem_we,
  input  logic                  mem_re,
  input  logic [MEM_ADDR_W-1:0] mem_addr,
  input  mem_word_t             wdata,
  output mem_word_t             rdata
);

  mem_word_t ram [2 ** MEM_ADDR_W];

  // One cycle read latency
  always_ff @(posedge ti_clk) begin
    if (mem_we) begin
      ram[mem_addr] <= wdata;
    end
    if (mem_re) begin
      rdata <= ram[mem_addr];
    end
  end

endmodule

// File: pipe_in_fifo.sv
// Input pipe packing 16-bit host words in pairs into a 32-bit FIFO
module pipe_in_fifo import ramtest_pkg::*; #(
  parameter int PIPE_DEPTH_W = 5
) (
  input  logic                  ti_clk,
  input  logic                  arst_n,
  input  logic                  soft_rst,
  input  logic                  pipe_in_write,
  input  pipe_word_t            pipe_in_data,
  input  logic                  in_pop,
  output logic                  pipe_in_full,
  output mem_word_t             in_data,
  output logic [PIPE_DEPTH_W:0] in_words
);

  localparam int DEPTH = 2 ** PIPE_DEPTH_W;

  mem_word_t               fifo_mem [DEPTH];
  logic [PIPE_DEPTH_W-1:0] wr_ptr_q;
  logic [PIPE_DEPTH_W-1:0] rd_ptr_q;
  logic [PIPE_DEPTH_W:0]   count_q;
  pipe_word_t              low_q;
  logic                    have_low_q;
  logic                    take;
  logic                    push;

  assign take = pipe_in_write && !pipe_in_full;
  assign push = take && have_low_q;

  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      have_low_q <= 1'b0;
    end else if (soft_rst) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      have_low_q <= 1'b0;
    end else begin
      if (take) have_low_q <= !have_low_q;
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (in_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + push - in_pop;
    end
  end

  // First word of a pair waits here, then goes to the low half
  always_ff @(posedge ti_clk) begin
    if (take && !have_low_q) low_q <= pipe_in_data;
    if (push) fifo_mem[wr_ptr_q] <= {pipe_in_data, low_q};
  end

  assign in_data      = fifo_mem[rd_ptr_q];
  assign in_words     = count_q;
  assign pipe_in_full = (count_q == DEPTH[PIPE_DEPTH_W:0]);

endmodule

// File: pipe_out_fifo.sv
// Output pipe storing 32-bit memory words and handing out 16-bit halves
module pipe_out_fifo import ramtest_pkg::*; #(
  parameter int PIPE_DEPTH_W = 5
) (
  input  logic                  ti_clk,
  input  logic                  arst_n,
  input  logic                  soft_rst,
  input  logic                  out_push,
  input  mem_word_t             out_data,
  input  logic                  pipe_out_read,
  output pipe_word_t            pipe_out_data,
  output logic                  pipe_out_empty,
  output logic [PIPE_DEPTH_W:0] out_space
);

  localparam int DEPTH = 2 ** PIPE_DEPTH_W;

  mem_word_t               fifo_mem [DEPTH];
  logic [PIPE_DEPTH_W-1:0] wr_ptr_q;
  logic [PIPE_DEPTH_W-1:0] rd_ptr_q;
  logic [PIPE_DEPTH_W:0]   count_q;
  logic                    hi_sel_q;
  logic                    take;
  logic                    pop;
  mem_word_t               head;

  assign take = pipe_out_read && !pipe_out_empty;
  // Head word leaves after its high half is read
  assign pop  = take && hi_sel_q;

  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      hi_sel_q <= 1'b0;
    end else if (soft_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      hi_sel_q <= 1'b0;
    end else begin
      if (take) hi_sel_q <= !hi_sel_q;
      if (out_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + out_push - pop;
    end
  end

  always_ff @(posedge ti_clk) begin
    if (out_push) fifo_mem[wr_ptr_q] <= out_data;
  end

  assign head           = fifo_mem[rd_ptr_q];
  assign pipe_out_data  = hi_sel_q ? head[MEM_W-1:PIPE_W] : head[PIPE_W-1:0];
  assign pipe_out_empty = (count_q == '0);
  assign out_space      = DEPTH[PIPE_DEPTH_W:0] - count_q;

endmodule

// File: burst_counter.sv
// Beat counter, wrapping memory addresses and unread burst count
module burst_counter #(
  parameter int BURST_LEN  = 8,
  parameter int MEM_ADDR_W = 8
) (
  input  logic                  ti_clk,
  input  logic                  arst_n,
  input  logic                  soft_rst,
  input  logic                  beat_inc,
  input  logic                  mem_we,
  input  logic                  burst_wr_done,
  input  logic                  burst_rd_done,
  output logic [MEM_ADDR_W-1:0] mem_addr,
  output logic                  last_beat,
  output logic [MEM_ADDR_W:0]   unread_bursts,
  output logic                  mem_full
);

  localparam int BEAT_W     = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
  localparam int MEM_BURSTS = (2 ** MEM_ADDR_W) / BURST_LEN;

  logic [BEAT_W-1:0]     beat_q;
  logic [MEM_ADDR_W-1:0] wr_addr_q;
  logic [MEM_ADDR_W-1:0] rd_addr_q;

  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_q        <= '0;
      wr_addr_q     <= '0;
      rd_addr_q     <= '0;
      unread_bursts <= '0;
    end else if (soft_rst) begin
      beat_q        <= '0;
      wr_addr_q     <= '0;
      rd_addr_q     <= '0;
      unread_bursts <= '0;
    end else begin
      if (beat_inc) begin
        beat_q <= last_beat ? '0 : beat_q + 1'b1;
        if (mem_we) begin
          wr_addr_q <= wr_addr_q + 1'b1;
        end else begin
          rd_addr_q <= rd_addr_q + 1'b1;
        end
      end
      // Only one burst in flight, so never both at once
      if (burst_wr_done) begin
        unread_bursts <= unread_bursts + 1'b1;
      end else if (burst_rd_done) begin
        unread_bursts <= unread_bursts - 1'b1;
      end
    end
  end

  assign last_beat = (beat_q == BEAT_W'(BURST_LEN - 1));
  assign mem_addr  = mem_we ? wr_addr_q : rd_addr_q;
  assign mem_full  = (unread_bursts == (MEM_ADDR_W + 1)'(MEM_BURSTS));

endmodule

// File: xfer_fsm.sv
// Transfer FSM choosing and sequencing memory write and read bursts
module xfer_fsm import ramtest_pkg::*; #(
  parameter int BURST_LEN    = 8,
  parameter int MEM_ADDR_W   = 8,
  parameter int PIPE_DEPTH_W = 5
) (
  input  logic                  ti_clk,
  input  logic                  arst_n,
  input  logic                  soft_rst,
  input  logic                  rd_en,
  input  logic                  wr_en,
  input  logic [PIPE_DEPTH_W:0] in_words,
  input  logic [PIPE_DEPTH_W:0] out_space,
  input  logic [MEM_ADDR_W:0]   unread_bursts,
  input  logic                  mem_full,
  input  logic                  last_beat,
  output logic                  in_pop,
  output logic                  mem_we,
  output logic                  mem_re,
  output logic                  out_push,
  output logic                  beat_inc,
  output logic                  burst_wr_done,
  output logic                  burst_rd_done
);

  xfer_state_t state_q;
  xfer_state_t state_d;
  logic        rd_valid_q;
  logic        rd_ok;
  logic        wr_ok;

  assign rd_ok = rd_en && (unread_bursts != '0) && (out_space >= BURST_LEN);
  assign wr_ok = wr_en && (in_words >= BURST_LEN) && !mem_full;

  always_comb begin
    state_d = state_q;
    case (state_q)
      XFER_IDLE: begin
        // Reads win over writes
        if (rd_ok) begin
          state_d = XFER_READ_ADDR;
        end else if (wr_ok) begin
          state_d = XFER_WRITE;
        end
      end
      XFER_WRITE:     if (last_beat) state_d = XFER_IDLE;
      XFER_READ_ADDR: if (last_beat) state_d = XFER_READ;
      XFER_READ:      state_d = XFER_IDLE;
      default:        state_d = XFER_IDLE;
    endcase
  end

  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= XFER_IDLE;
      rd_valid_q <= 1'b0;
    end else if (soft_rst) begin
      state_q    <= XFER_IDLE;
      rd_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      rd_valid_q <= mem_re;
    end
  end

  // --------------------------------------------------
  // Burst strobes
  // --------------------------------------------------
  assign mem_we        = (state_q == XFER_WRITE);
  assign in_pop        = mem_we;
  assign mem_re        = (state_q == XFER_READ_ADDR);
  assign beat_inc      = mem_we || mem_re;
  assign burst_wr_done = mem_we && last_beat;
  assign burst_rd_done = (state_q == XFER_READ);

  // Read data lands one cycle after its address
  assign out_push = rd_valid_q;

endmodule

// File: ctrl_regs.sv
// Wishbone classic slave with the control register and burst status readback
module ctrl_regs import ramtest_pkg::*; #(
  parameter int MEM_ADDR_W = 8
) (
  input  logic                ti_clk,
  input  logic                arst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  wb_addr_t            wb_adr,
  input  wb_data_t            wb_dat_w,
  input  logic [MEM_ADDR_W:0] unread_bursts,
  output logic                wb_ack,
  output wb_data_t            wb_dat_r,
  output logic                rd_en,
  output logic                wr_en,
  output logic                soft_rst
);

  logic     [2:0] ctrl_q;
  logic           access;
  wb_data_t       rd_mux;

  // Ack low for a cycle between accesses
  assign access = wb_cyc && wb_stb && !wb_ack;

  always_comb begin
    case (wb_adr)
      CTRL_ADDR: rd_mux = wb_data_t'(ctrl_q);
      STAT_ADDR: rd_mux = wb_data_t'(unread_bursts);
      default:   rd_mux = '0;
    endcase
  end

  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      ctrl_q   <= '0;
    end else begin
      wb_ack <= access;
      if (access) begin
        wb_dat_r <= rd_mux;
        if (wb_we && wb_adr == CTRL_ADDR) begin
          ctrl_q <= wb_dat_w[2:0];
        end
      end
    end
  end

  assign rd_en    = ctrl_q[CTRL_RD_BIT];
  assign wr_en    = ctrl_q[CTRL_WR_BIT];
  assign soft_rst = ctrl_q[CTRL_RST_BIT];

endmodule

// File: ramtest_top.sv
// Host-to-memory loopback engine with Wishbone control and 16-bit pipes
module ramtest_top import ramtest_pkg::*; #(
  parameter int BURST_LEN    = 8,
  parameter int MEM_ADDR_W   = 8,
  parameter int PIPE_DEPTH_W = 5
) (
  input  logic       ti_clk,
  input  logic       arst_n,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  wb_addr_t   wb_adr,
  input  wb_data_t   wb_dat_w,
  output logic       wb_ack,
  output wb_data_t   wb_dat_r,
  input  logic       pipe_in_write,
  input  pipe_word_t pipe_in_data,
  output logic       pipe_in_full,
  input  logic       pipe_out_read,
  output pipe_word_t pipe_out_data,
  output logic       pipe_out_empty
);

  logic                  rd_en;
  logic                  wr_en;
  logic                  soft_rst;
  logic                  in_pop;
  logic                  mem_we;
  logic                  mem_re;
  logic                  out_push;
  logic                  beat_inc;
  logic                  burst_wr_done;
  logic                  burst_rd_done;
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic                  last_beat;
  logic [MEM_ADDR_W:0]   unread_bursts;
  logic                  mem_full;
  mem_word_t             in_data;
  mem_word_t             rdata;
  logic [PIPE_DEPTH_W:0] in_words;
  logic [PIPE_DEPTH_W:0] out_space;

  ctrl_regs #(.MEM_ADDR_W(MEM_ADDR_W)) ctrl_regs_i (
    .ti_clk, .arst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .unread_bursts,
    .wb_ack, .wb_dat_r,
    .rd_en, .wr_en, .soft_rst
  );

  xfer_fsm #(
    .BURST_LEN(BURST_LEN), .MEM_ADDR_W(MEM_ADDR_W), .PIPE_DEPTH_W(PIPE_DEPTH_W)
  ) xfer_fsm_i (
    .ti_clk, .arst_n, .soft_rst, .rd_en, .wr_en,
    .in_words, .out_space, .unread_bursts, .mem_full, .last_beat,
    .in_pop, .mem_we, .mem_re, .out_push,
    .beat_inc, .burst_wr_done, .burst_rd_done
  );

  burst_counter #(.BURST_LEN(BURST_LEN), .MEM_ADDR_W(MEM_ADDR_W)) burst_counter_i (
    .ti_clk, .arst_n, .soft_rst,
    .beat_inc, .mem_we, .burst_wr_done, .burst_rd_done,
    .mem_addr, .last_beat, .unread_bursts, .mem_full
  );

  pipe_in_fifo #(.PIPE_DEPTH_W(PIPE_DEPTH_W)) pipe_in_fifo_i (
    .ti_clk, .arst_n, .soft_rst,
    .pipe_in_write, .pipe_in_data, .in_pop,
    .pipe_in_full, .in_data, .in_words
  );

  pipe_out_fifo #(.PIPE_DEPTH_W(PIPE_DEPTH_W)) pipe_out_fifo_i (
    .ti_clk, .arst_n, .soft_rst,
    .out_push, .out_data(rdata), .pipe_out_read,
    .pipe_out_data, .pipe_out_empty, .out_space
  );

  word_ram #(.MEM_ADDR_W(MEM_ADDR_W)) word_ram_i (
    .ti_clk, .mem_we, .mem_re, .mem_addr,
    .wdata(in_data), .rdata
  );

endmodule

// File: tb_ramtest.sv
// Table-driven testbench for the loopback engine over Wishbone and both pipes
module tb_ramtest import ramtest_pkg::*; ();

  localparam int BURST_LEN  = 8;
  localparam int WAIT_LIMIT = 2000;

  typedef enum {OP_WR, OP_RD, OP_POLL, OP_PUSH, OP_POP, OP_EMPTY, OP_FULL, OP_WAIT} op_t;

  typedef struct {
    op_t      op;
    wb_addr_t adr;
    wb_data_t data;
    int       count;
    string    label;
  } step_t;

  logic       ti_clk;
  logic       arst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_addr_t   wb_adr;
  wb_data_t   wb_dat_w;
  logic       wb_ack;
  wb_data_t   wb_dat_r;
  logic       pipe_in_write;
  pipe_word_t pipe_in_data;
  logic       pipe_in_full;
  logic       pipe_out_read;
  pipe_word_t pipe_out_data;
  logic       pipe_out_empty;

  step_t      steps [$];
  pipe_word_t expect_q [$];
  int         err_count;
  int         check_count;

  ramtest_top ramtest_top_i (
    .ti_clk, .arst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .wb_ack, .wb_dat_r,
    .pipe_in_write, .pipe_in_data, .pipe_in_full,
    .pipe_out_read, .pipe_out_data, .pipe_out_empty
  );

  initial begin
    ti_clk = 1'b0;
    forever #4 ti_clk = ~ti_clk;
  end

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_wb(input string name, input wb_data_t got, input wb_data_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_pipe(input string name, input pipe_word_t got, input pipe_word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Bus and pipe drivers, all entered on a falling edge
  // --------------------------------------------------
  task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat_w,
                           output wb_data_t dat_r);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat_w;
    @(negedge ti_clk);
    while (!wb_ack && waited < WAIT_LIMIT) begin
      @(negedge ti_clk);
      waited++;
    end
    if (!wb_ack) begin
      err_count++;
      $display("Wishbone access to address %0d was never acknowledged", adr);
    end
    dat_r  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // Ack drops on the next edge
    @(negedge ti_clk);
    check_bit("wb_ack", wb_ack, 1'b0);
  endtask

  task automatic poll_reg(input wb_addr_t adr, input wb_data_t exp);
    wb_data_t got;
    int       tries;
    tries = 0;
    wb_access(1'b0, adr, '0, got);
    while (got !== exp && tries < WAIT_LIMIT / 4) begin
      wb_access(1'b0, adr, '0, got);
      tries++;
    end
    if (got !== exp) begin
      $display("Register %0d did not settle before the timeout", adr);
    end
    check_wb("wb_dat_r", got, exp);
  endtask

  task automatic push_words(input int count);
    pipe_word_t word;
    int         waited;
    for (int i = 0; i < count; i++) begin
      waited = 0;
      while (pipe_in_full && waited < WAIT_LIMIT) begin
        pipe_in_write = 1'b0;
        @(negedge ti_clk);
        waited++;
      end
      if (pipe_in_full) begin
        err_count++;
        $display("Input pipe stayed full, push of word %0d abandoned", i);
        pipe_in_write = 1'b0;
        return;
      end
      word          = pipe_word_t'($urandom());
      pipe_in_data  = word;
      pipe_in_write = 1'b1;
      expect_q.push_back(word);
      @(negedge ti_clk);
    end
    pipe_in_write = 1'b0;
  endtask

  task automatic pop_words(input int count);
    int waited;
    for (int i = 0; i < count; i++) begin
      waited = 0;
      while (pipe_out_empty && waited < WAIT_LIMIT) begin
        pipe_out_read = 1'b0;
        @(negedge ti_clk);
        waited++;
      end
      if (pipe_out_empty) begin
        err_count++;
        $display("Output pipe stayed empty, %0d of %0d words popped", i, count);
        pipe_out_read = 1'b0;
        return;
      end
      if (expect_q.size() == 0) begin
        err_count++;
        $display("Output pipe returned a word that was never pushed");
      end else begin
        check_pipe("pipe_out_data", pipe_out_data, expect_q.pop_front());
      end
      pipe_out_read = 1'b1;
      @(negedge ti_clk);
    end
    pipe_out_read = 1'b0;
  endtask

  task automatic wait_data();
    int waited;
    waited = 0;
    while (pipe_out_empty && waited < WAIT_LIMIT) begin
      @(negedge ti_clk);
      waited++;
    end
    if (pipe_out_empty) begin
      err_count++;
      $display("No data reached the output pipe before the timeout");
    end
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  function automatic void add_step(input op_t op, input wb_addr_t adr, input wb_data_t data,
                                   input int count, input string label);
    step_t s;
    s.op    = op;
    s.adr   = adr;
    s.data  = data;
    s.count = count;
    s.label = label;
    steps.push_back(s);
  endfunction

  function automatic void build_table();
    add_step(OP_RD,    CTRL_ADDR, 16'h0000, 0, "control after reset");
    add_step(OP_RD,    STAT_ADDR, 16'h0000, 0, "status after reset");
    add_step(OP_EMPTY, '0,        16'h0001, 0, "output empty after reset");
    add_step(OP_FULL,  '0,        16'h0000, 0, "input not full after reset");
    add_step(OP_WR,    CTRL_ADDR, 16'hffff, 0, "control write all ones");
    add_step(OP_RD,    CTRL_ADDR, 16'h0007, 0, "control keeps three bits");
    add_step(OP_WR,    STAT_ADDR, 16'h1234, 0, "status write");
    add_step(OP_RD,    STAT_ADDR, 16'h0000, 0, "status ignores writes");
    add_step(OP_WR,    2'd2,      16'habcd, 0, "unused address write");
    add_step(OP_RD,    2'd2,      16'h0000, 0, "unused address reads zero");
    add_step(OP_WR,    CTRL_ADDR, 16'h0002, 0, "writes only");
    add_step(OP_PUSH,  '0,        '0, 4 * BURST_LEN, "push two bursts");
    add_step(OP_POLL,  STAT_ADDR, 16'h0002, 0, "two bursts unread");
    add_step(OP_EMPTY, '0,        16'h0001, 0, "no output without reads");
    add_step(OP_PUSH,  '0,        '0, 2 * BURST_LEN - 2, "push partial burst");
    add_step(OP_RD,    STAT_ADDR, 16'h0002, 0, "partial burst not written");
    add_step(OP_EMPTY, '0,        16'h0001, 0, "output still empty");
    add_step(OP_WR,    CTRL_ADDR, 16'h0003, 0, "reads and writes");
    add_step(OP_POP,   '0,        '0, 4 * BURST_LEN, "pop two bursts");
    add_step(OP_POLL,  STAT_ADDR, 16'h0000, 0, "nothing unread");
    add_step(OP_PUSH,  '0,        '0, 64, "push 64 words");
    // Two more words close the open burst
    add_step(OP_PUSH,  '0,        '0, 2, "push burst filler");
    add_step(OP_POP,   '0,        '0, 80, "pop remainder and 64 words");
    add_step(OP_POLL,  STAT_ADDR, 16'h0000, 0, "nothing unread again");
    add_step(OP_EMPTY, '0,        16'h0001, 0, "output drained");
    // Output pipe takes four bursts, the last two stay in memory
    add_step(OP_PUSH,  '0,        '0, 12 * BURST_LEN, "push before soft reset");
    add_step(OP_WAIT,  '0,        '0, 0, "data in output pipe");
    add_step(OP_POLL,  STAT_ADDR, 16'h0002, 0, "two bursts held in memory");
    add_step(OP_WR,    CTRL_ADDR, 16'h0007, 0, "soft reset on");
    add_step(OP_RD,    CTRL_ADDR, 16'h0007, 0, "control held in soft reset");
    add_step(OP_WR,    CTRL_ADDR, 16'h0003, 0, "soft reset off");
    add_step(OP_RD,    STAT_ADDR, 16'h0000, 0, "status cleared");
    add_step(OP_EMPTY, '0,        16'h0001, 0, "output cleared");
    add_step(OP_FULL,  '0,        16'h0000, 0, "input cleared");
    add_step(OP_RD,    CTRL_ADDR, 16'h0003, 0, "control kept");
  endfunction

  initial begin
    step_t    s;
    wb_data_t rd;
    int       errs_before;
    arst_n        = 1'b0;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    pipe_in_write = 1'b0;
    pipe_in_data  = '0;
    pipe_out_read = 1'b0;
    err_count     = 0;
    check_count   = 0;
    void'($urandom(32'h7335d4a6));
    build_table();
    repeat (3) @(posedge ti_clk);
    @(negedge ti_clk);
    arst_n = 1'b1;
    @(negedge ti_clk);
    for (int i = 0; i < steps.size(); i++) begin
      s           = steps[i];
      errs_before = err_count;
      case (s.op)
        OP_WR: begin
          wb_access(1'b1, s.adr, s.data, rd);
          // Soft reset drops every word still in flight
          if (s.adr == CTRL_ADDR && s.data[CTRL_RST_BIT]) begin
            expect_q.delete();
          end
        end
        OP_RD: begin
          wb_access(1'b0, s.adr, '0, rd);
          check_wb("wb_dat_r", rd, s.data);
        end
        OP_POLL:  poll_reg(s.adr, s.data);
        OP_PUSH:  push_words(s.count);
        OP_POP:   pop_words(s.count);
        OP_EMPTY: check_bit("pipe_out_empty", pipe_out_empty, s.data[0]);
        OP_FULL:  check_bit("pipe_in_full", pipe_in_full, s.data[0]);
        OP_WAIT:  wait_data();
        default:  ;
      endcase
      if (err_count == errs_before) begin
        $display("test %0d %s: ok", i, s.label);
      end else begin
        $display("test %0d %s: %0d errors", i, s.label, err_count - errs_before);
      end
    end
    $display("%0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: filelist.f
ramtest_pkg.sv
word_ram.sv
pipe_in_fifo.sv
pipe_out_fifo.sv
burst_counter.sv
xfer_fsm.sv
ctrl_regs.sv
ramtest_top.sv
tb_ramtest.sv

// File: Bender.yml
package:
  name: ramtest

sources:
  - ramtest_pkg.sv
  - word_ram.sv
  - pipe_in_fifo.sv
  - pipe_out_fifo.sv
  - burst_counter.sv
  - xfer_fsm.sv
  - ctrl_regs.sv
  - ramtest_top.sv
  - target: test
    files:
      - tb_ramtest.sv
